/* approx_dot_top.f */
+incdir+verif
rtl/approx_dot_pkg.sv
rtl/stream_if.sv
rtl/approx_mul16.sv
rtl/pipe_reg.sv
rtl/dot_accum.sv
rtl/approx_dot_top.sv
verif/tb_approx_dot.sv

/* rtl/approx_dot_pkg.sv */
`default_nettype none

package approx_dot_pkg;

    // Operand width is tied to the approximate multiplier structure
    localparam int OP_W = 16;
    localparam int PROD_W = 32;

    localparam int ACC_W_DEFAULT = 40; // Default vector sum width

    // One operand pair, x in the upper half
    typedef struct packed {
        logic signed [OP_W-1:0] x;
        logic signed [OP_W-1:0] y;
    } operand_t;

    typedef logic signed [PROD_W-1:0] product_t;

endpackage

`default_nettype wire

/* rtl/approx_dot_top.sv */
`timescale 1ns/100ps
`default_nettype none

// Streaming approximate dot product
// operand slice -> approx multiplier -> product slice -> accumulator
module approx_dot_top #(
    parameter int ACC_W = approx_dot_pkg::ACC_W_DEFAULT
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic signed [approx_dot_pkg::OP_W-1:0]   in_x,
    input  logic signed [approx_dot_pkg::OP_W-1:0]   in_y,
    input  logic                                     in_last,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic signed [ACC_W-1:0]                  out_sum
);

    stream_if #(.T(approx_dot_pkg::operand_t)) op_s ();
    stream_if #(.T(approx_dot_pkg::operand_t)) op_q ();
    stream_if #(.T(approx_dot_pkg::product_t)) prod_s ();
    stream_if #(.T(approx_dot_pkg::product_t)) prod_q ();

    assign op_s.valid = in_valid;
    assign op_s.data  = {in_x, in_y};
    assign op_s.last  = in_last;
    assign in_ready   = op_s.ready;

    pipe_reg #(
        .T(approx_dot_pkg::operand_t)
    ) u_op_reg (
        .clk (clk),
        .rst (rst),
        .s   (op_s),
        .m   (op_q)
    );

    approx_mul16 u_mul (
        .x (op_q.data.x),
        .y (op_q.data.y),
        .z (prod_s.data)
    );

    // Multiplier adds no cycle, so the operand handshake passes straight through
    assign prod_s.valid = op_q.valid;
    assign prod_s.last  = op_q.last;
    assign op_q.ready   = prod_s.ready;

    pipe_reg #(
        .T(approx_dot_pkg::product_t)
    ) u_prod_reg (
        .clk (clk),
        .rst (rst),
        .s   (prod_s),
        .m   (prod_q)
    );

    dot_accum #(
        .ACC_W(ACC_W)
    ) u_accum (
        .clk       (clk),
        .rst       (rst),
        .s         (prod_q),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

endmodule

`default_nettype wire

/* rtl/approx_mul16.sv */
`timescale 1ns/100ps
`default_nettype none

// Approximate signed 16x16 Baugh-Wooley multiplier
// Rows 7 to 16 are summed exactly, rows 1 to 6 collapse into five sparse correction words
module approx_mul16 (
    input  logic signed [15:0] x,
    input  logic signed [15:0] y,
    output logic signed [31:0] z
);

    logic [15:0] row [1:16];
    logic [20:0] corr [1:5];
    logic [31:0] exact;
    logic [31:0] corr_sum;

    // Partial product rows, row i uses x[i-1]
    for (genvar i = 1; i <= 16; i++) begin : g_row
        if (i < 16) begin : g_pos
            assign row[i] = {~(y[15] & x[i-1]), y[14:0] & {15{x[i-1]}}};
        end else begin : g_neg
            // Sign row of x, low bits inverted
            assign row[i] = {y[15] & x[i-1], ~(y[14:0] & {15{x[i-1]}})};
        end
    end

    always_comb begin
        exact = 32'h8000_0000; // Baugh-Wooley constant at bit 31
        for (int i = 7; i <= 16; i++) begin
            exact = exact + (32'(row[i]) << (i - 1));
        end
    end

    // Correction words keep only selected bit pairs of the low rows
    always_comb begin
        for (int k = 1; k <= 5; k++) begin
            corr[k] = '0;
        end

        corr[1][3]  = row[1][3] ^ row[2][2];
        corr[1][5]  = row[1][5] ^ row[2][4];
        corr[1][6]  = row[5][1] & row[6][0];
        corr[1][11] = row[5][6] & row[6][5];
        corr[1][12] = row[1][12] ^ row[2][11];
        corr[1][13] = row[1][12] & row[2][11]; // Carry of the pair above
        corr[1][14] = row[1][14] ^ row[2][13];
        corr[1][15] = row[3][13] ^ row[4][12];
        corr[1][16] = row[5][11] & row[6][10];
        corr[1][17] = row[2][15];
        corr[1][18] = row[3][15] & row[4][14];
        corr[1][19] = row[5][14] & row[6][13];
        corr[1][20] = row[5][15] & row[6][14];

        corr[2][5]  = row[3][2] & row[4][1];
        corr[2][13] = row[5][9] ^ row[6][8];
        corr[2][15] = row[5][11] ^ row[6][10];
        corr[2][17] = row[3][14] & row[4][13];
        corr[2][18] = row[4][15];
        corr[2][19] = row[5][15] ^ row[6][14];
        corr[2][20] = row[6][15];

        corr[3][17] = row[3][15] ^ row[4][14];
        corr[3][18] = row[5][13] & row[6][12];

        corr[4][17] = row[5][12] & row[6][11];
        corr[4][18] = row[5][14] ^ row[6][13];

        corr[5][17] = row[5][13] ^ row[6][12];
    end

    always_comb begin
        corr_sum = '0;
        for (int k = 1; k <= 5; k++) begin
            corr_sum = corr_sum + 32'(corr[k]);
        end
    end

    // Sum wraps at 32 bits, which gives the signed result
    assign z = exact + corr_sum;

endmodule

`default_nettype wire

/* rtl/dot_accum.sv */
`timescale 1ns/100ps
`default_nettype none

// Sums the products of one vector and holds the result for the output stream
module dot_accum #(
    parameter int ACC_W = 40
) (
    input  logic                    clk,
    input  logic                    rst,
    stream_if.snk                   s,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic signed [ACC_W-1:0] out_sum
);

    logic                    first;    // Next product opens a vector
    logic signed [ACC_W-1:0] run_sum;
    logic signed [ACC_W-1:0] prod_ext;
    logic signed [ACC_W-1:0] next_sum;
    logic                    s_fire;

    if (ACC_W < approx_dot_pkg::PROD_W) begin : g_width_check
        $error("dot_accum: ACC_W narrower than the product");
    end

    // A new vector end may only land once the held sum is taken
    assign s.ready = !out_valid || out_ready;
    assign s_fire  = s.valid && s.ready;

    assign prod_ext = s.data; // Sign extension to ACC_W
    assign next_sum = (first ? '0 : run_sum) + prod_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            first     <= 1'b1;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (s_fire) begin
                first <= s.last;
                if (s.last) begin
                    out_valid <= 1'b1; // Overrides the drain in the same cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            run_sum <= next_sum;
            if (s.last) begin
                out_sum <= next_sum;
            end
        end
    end

    // Product slice keeps its item while the held sum stalls it
    a_in_hold : assert property (
        @(posedge clk) disable iff (rst)
        s.valid && !s.ready |=> s.valid && $stable(s.data) && $stable(s.last)
    ) else $error("dot_accum: product changed while stalled");

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

// One-entry register slice, full throughput on a steady stream
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    stream_if.snk s,
    stream_if.src m
);

    logic full;
    T     data_q;
    logic last_q;
    logic s_fire;

    assign s_fire  = s.valid && s.ready;
    assign s.ready = !full || m.ready; // Empty, or draining this cycle

    assign m.valid = full;
    assign m.data  = data_q;
    assign m.last  = last_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (s_fire) begin
            full <= 1'b1;
        end else if (m.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            data_q <= s.data;
            last_q <= s.last;
        end
    end

    // Upstream must hold its item while stalled
    a_src_stable : assert property (
        @(posedge clk) disable iff (rst)
        s.valid && !s.ready |=> $stable(s.data) && $stable(s.last)
    ) else $error("pipe_reg: input changed while stalled");

endmodule

`default_nettype wire

/* rtl/stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Valid/ready stream with a last flag marking the end of a vector
interface stream_if #(
    parameter type T = logic
) ();

    logic valid;
    logic ready;
    T     data;
    logic last;

    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the approximate dot-product testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_approx_dot \
    -Mdir "$OBJ" \
    -f approx_dot_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_approx_dot" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference model of the approximate product and the wrapped vector sum
// Rows 1 to 6 only reach the result through the sparse correction terms

function automatic logic [31:0] weighted_bit(input logic b, input int pos);
    return {31'b0, b} << pos;
endfunction

function automatic approx_dot_pkg::product_t model_product(
    input logic signed [15:0] x,
    input logic signed [15:0] y
);
    logic [15:0] pp [1:16];
    logic [31:0] total;
    logic        b;

    for (int i = 1; i <= 16; i++) begin
        for (int j = 0; j < 16; j++) begin
            b = y[j] & x[i-1];
            if (i < 16) begin
                pp[i][j] = (j == 15) ? ~b : b;    // Sign column inverted
            end else begin
                pp[i][j] = (j == 15) ? b : ~b;    // Sign row of x
            end
        end
    end

    total = 32'h8000_0000;
    for (int i = 7; i <= 16; i++) begin
        total = total + ({16'b0, pp[i]} << (i - 1));
    end

    // Correction terms by weight
    total = total + weighted_bit(pp[1][3] ^ pp[2][2], 3);
    total = total + weighted_bit(pp[1][5] ^ pp[2][4], 5);
    total = total + weighted_bit(pp[3][2] & pp[4][1], 5);
    total = total + weighted_bit(pp[5][1] & pp[6][0], 6);
    total = total + weighted_bit(pp[5][6] & pp[6][5], 11);
    total = total + weighted_bit(pp[1][12] ^ pp[2][11], 12);
    total = total + weighted_bit(pp[1][12] & pp[2][11], 13);
    total = total + weighted_bit(pp[5][9] ^ pp[6][8], 13);
    total = total + weighted_bit(pp[1][14] ^ pp[2][13], 14);
    total = total + weighted_bit(pp[3][13] ^ pp[4][12], 15);
    total = total + weighted_bit(pp[5][11] ^ pp[6][10], 15);
    total = total + weighted_bit(pp[5][11] & pp[6][10], 16);
    total = total + weighted_bit(pp[2][15], 17);
    total = total + weighted_bit(pp[3][14] & pp[4][13], 17);
    total = total + weighted_bit(pp[3][15] ^ pp[4][14], 17);
    total = total + weighted_bit(pp[5][12] & pp[6][11], 17);
    total = total + weighted_bit(pp[5][13] ^ pp[6][12], 17);
    total = total + weighted_bit(pp[3][15] & pp[4][14], 18);
    total = total + weighted_bit(pp[4][15], 18);
    total = total + weighted_bit(pp[5][13] & pp[6][12], 18);
    total = total + weighted_bit(pp[5][14] ^ pp[6][13], 18);
    total = total + weighted_bit(pp[5][14] & pp[6][13], 19);
    total = total + weighted_bit(pp[5][15] ^ pp[6][14], 19);
    total = total + weighted_bit(pp[5][15] & pp[6][14], 20);
    total = total + weighted_bit(pp[6][15], 20);

    return total;    // Bit 31 is the sign
endfunction

function automatic logic signed [ACC_W-1:0] model_accumulate(
    input logic signed [ACC_W-1:0] sum,
    input approx_dot_pkg::product_t p
);
    logic signed [ACC_W-1:0] p_ext;

    p_ext = ACC_W'(p);
    return sum + p_ext;    // Wraps at ACC_W bits
endfunction

`endif

/* verif/tb_approx_dot.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_approx_dot;

    localparam int ACC_W   = 40;
    localparam int TIMEOUT = 1000;    // Cycles allowed for any single wait
    localparam int LATENCY = 3;       // Operand slice, product slice, accumulator

    logic                                   clk;
    logic                                   rst;
    logic                                   in_valid;
    logic                                   in_ready;
    logic signed [approx_dot_pkg::OP_W-1:0] in_x;
    logic signed [approx_dot_pkg::OP_W-1:0] in_y;
    logic                                   in_last;
    logic                                   out_valid;
    logic                                   out_ready;
    logic signed [ACC_W-1:0]                out_sum;

    logic                    bp_en;      // Random output back-pressure
    logic                    aborted;
    int                      errors;
    int                      checks;
    logic signed [ACC_W-1:0] exp_q [$];

    `include "tb_model.svh"

    approx_dot_top #(
        .ACC_W(ACC_W)
    ) i_approx_dot_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_sum(input logic signed [ACC_W-1:0] got,
                             input logic signed [ACC_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0d ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %-14s %s (%0d errors)", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    task automatic next_edge();
        @(posedge clk);
        if (bp_en) begin
            out_ready <= ($urandom_range(0, 2) != 0);
        end
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n) next_edge();
    endtask

    // Returns at the edge that accepts the pair
    task automatic send_pair(input logic signed [15:0] x, input logic signed [15:0] y,
                             input logic last);
        int   n;
        logic rdy;

        if (aborted) begin
            return;
        end
        in_valid <= 1'b1;
        in_x     <= x;
        in_y     <= y;
        in_last  <= last;
        n   = 0;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = in_ready;
            next_edge();
            n++;
            if (!rdy && n >= TIMEOUT) begin
                report_timeout("input handshake");
                return;
            end
        end
    endtask

    task automatic send_vector(input int len, input int gap_pct);
        logic signed [15:0]      x;
        logic signed [15:0]      y;
        logic signed [ACC_W-1:0] sum;

        sum = '0;
        for (int k = 0; k < len; k++) begin
            x   = 16'($urandom);
            y   = 16'($urandom);
            sum = model_accumulate(sum, model_product(x, y));
            if (gap_pct > 0 && $urandom_range(0, 99) < gap_pct) begin
                idle_cycles($urandom_range(1, 3));
            end
            if (k == len - 1) begin
                exp_q.push_back(sum);
            end
            send_pair(x, y, k == len - 1);
        end
    endtask

    task automatic wait_drain(input string what);
        int n;

        n = 0;
        while (exp_q.size() != 0 && !aborted) begin
            next_edge();
            n++;
            if (n >= TIMEOUT && exp_q.size() != 0) begin
                report_timeout(what);
            end
        end
    endtask

    // Sampled at the falling edge, the handshake completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0d ns: unexpected sum %0d on the output", $time, out_sum);
            end else begin
                check_sum(out_sum, exp_q.pop_front(), "vector sum");
            end
        end
    end

    task automatic test_reset();
        int e0;

        e0 = errors;
        @(negedge clk);
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        @(posedge clk);
        finish_test("reset state", e0);
    endtask

    task automatic test_corners();
        logic signed [15:0] vals [5];
        int                 e0;

        e0   = errors;
        vals = '{16'h0000, 16'h0001, 16'hffff, 16'h7fff, 16'h8000};
        for (int a = 0; a < 5; a++) begin
            for (int b = 0; b < 5; b++) begin
                exp_q.push_back(model_accumulate('0, model_product(vals[a], vals[b])));
                send_pair(vals[a], vals[b], 1'b1);
            end
        end
        in_valid <= 1'b0;
        wait_drain("corner sums");
        finish_test("corner products", e0);
    endtask

    task automatic test_vectors(input string name, input int gap_pct, input logic bp);
        int e0;

        e0    = errors;
        bp_en = bp;
        for (int v = 0; v < 20; v++) begin
            send_vector($urandom_range(1, 20), gap_pct);
        end
        in_valid <= 1'b0;
        wait_drain(name);
        bp_en = 1'b0;
        out_ready <= 1'b1;
        next_edge();
        finish_test(name, e0);
    endtask

    task automatic test_latency();
        int   lens [3];
        int   e0;
        int   cycles;
        logic seen;

        e0   = errors;
        lens = '{1, 5, 2};
        for (int v = 0; v < 3; v++) begin
            send_vector(lens[v], 0);
            in_valid <= 1'b0;
            cycles = 1;    // The accepting edge counts as the first
            seen   = 1'b0;
            while (!seen && !aborted) begin
                @(negedge clk);
                seen = out_valid;
                if (!seen) begin
                    next_edge();
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        report_timeout("out_valid after the last pair");
                    end
                end
            end
            if (seen) begin
                check_cycles(cycles, LATENCY, "last pair to out_valid");
            end
            next_edge();    // Back on a rising edge before the next vector
            wait_drain("latency sum");
        end
        finish_test("latency", e0);
    endtask

    initial begin
        void'($urandom(32'h985c_2341));
        errors    = 0;
        checks    = 0;
        aborted   = 1'b0;
        bp_en     = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_x      = '0;
        in_y      = '0;
        in_last   = 1'b0;
        out_ready = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_corners();
        test_vectors("random vectors", 0, 1'b0);
        test_vectors("back-pressure", 0, 1'b1);
        test_vectors("input gaps", 30, 1'b0);
        test_latency();

        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
